/* frontend.f */
+incdir+include
rtl/fetch_types_pkg.sv
rtl/branch_types_pkg.sv
rtl/pc_reg.sv
rtl/bpu.sv
rtl/fetch_fsm.sv
rtl/inst_buffer.sv
rtl/frontend_top.sv
verification/imem_wb_slave.sv
verification/frontend_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = frontend_tb
FILELIST = frontend.f
SIM      = frontend_sim
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL) and run $(TOP), result in $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(SIM)
	./obj_dir/$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then exit 1; fi
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verification/frontend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "frontend_cfg.svh"

module frontend_tb
    import fetch_types_pkg::*, branch_types_pkg::*;
;

    logic  clk, arst_n;
    logic  wb_cyc, wb_stb, wb_ack;
    addr_t wb_adr;
    inst_t wb_dat;
    logic  redirect_valid, update_valid, update_taken, out_ready;
    addr_t redirect_pc, update_pc, update_target;
    logic  out_valid, out_pred_taken, buffer_full;
    addr_t out_pc, out_pred_target;
    inst_t out_inst;

    // Branch target buffer model, indexed by pc bits 5:2
    logic     m_valid  [16];
    btb_tag_t m_tag    [16];
    addr_t    m_target [16];
    sat_cnt_t m_cnt    [16];

    addr_t exp_pc, last_pc, last_target;
    logic  last_taken, prev_full, prev_cyc;
    logic  rand_mode = 1'b0;
    logic  ready_rand = 1'b0;
    int    errors = 0;
    int    delivered = 0;
    int    tests_run = 0;
    int    tests_failed = 0;

    frontend_top dut0 (
        .clk, .arst_n,
        .wb_cyc, .wb_stb, .wb_adr, .wb_dat_i(wb_dat), .wb_ack,
        .redirect_valid, .redirect_pc,
        .update_valid, .update_pc, .update_target, .update_taken,
        .out_valid, .out_ready, .out_pc, .out_inst, .out_pred_taken, .out_pred_target,
        .buffer_full
    );

    imem_wb_slave imem0 (
        .clk, .arst_n, .wb_cyc, .wb_stb, .wb_adr, .wb_dat, .wb_ack
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic inst_t expected_word(input addr_t adr);
        return {adr[15:0] ^ 16'ha70b, ~adr[31:16]};
    endfunction

    function automatic logic model_hit(input addr_t pc);
        return m_valid[pc[5:2]] && m_tag[pc[5:2]] == pc[31:6];
    endfunction

    task automatic model_update(input addr_t pc, input addr_t tgt, input logic taken);
        logic [3:0] i;
        i = pc[5:2];
        if (taken && !model_hit(pc)) begin
            m_valid[i]  = 1'b1;
            m_tag[i]    = pc[31:6];
            m_target[i] = tgt;
            m_cnt[i]    = 2'd2;
        end else if (taken) begin
            m_target[i] = tgt;
            if (m_cnt[i] != 2'd3) m_cnt[i] = m_cnt[i] + 2'd1;
        end else if (model_hit(pc) && m_cnt[i] != 2'd0) begin
            m_cnt[i] = m_cnt[i] - 2'd1;
        end
    endtask

    task automatic check_pc(input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("Error at %0t: pc %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_inst(input inst_t got, input inst_t exp);
        if (got !== exp) begin
            $display("Error at %0t: instruction %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_pred(input logic got_taken, input addr_t got_tgt,
                              input logic exp_taken, input addr_t exp_tgt);
        if (got_taken !== exp_taken || got_tgt !== exp_tgt) begin
            $display("Error at %0t: prediction %b/%h, expected %b/%h", $time,
                     got_taken, got_tgt, exp_taken, exp_tgt);
            errors++;
        end
    endtask

    // Stream monitor, sampled mid-cycle where every output has settled
    always @(negedge clk) begin
        logic  taken;
        addr_t tgt;
        if (!arst_n) begin
            exp_pc = `FE_RESET_PC;
            for (int i = 0; i < 16; i++) m_valid[i] = 1'b0;
        end else if (redirect_valid) begin
            exp_pc = redirect_pc; // Buffer is flushed on this edge
            if (update_valid) model_update(update_pc, update_target, update_taken);
        end else if (out_valid && out_ready) begin
            taken = model_hit(out_pc) && m_cnt[out_pc[5:2]][1];
            tgt   = taken ? m_target[out_pc[5:2]] : out_pc + 32'd4;
            check_pc(out_pc, exp_pc);
            check_inst(out_inst, expected_word(out_pc));
            check_pred(out_pred_taken, out_pred_target, taken, tgt);
            last_pc     = out_pc;
            last_taken  = out_pred_taken;
            last_target = out_pred_target;
            exp_pc      = tgt;
            delivered++;
        end
        if (arst_n && prev_full && !prev_cyc && wb_cyc) begin
            $display("Fetch cycle started while the buffer was full at %0t", $time);
            errors++;
        end
        prev_full = buffer_full;
        prev_cyc  = wb_cyc;
    end

    // Background random stimulus
    always @(posedge clk) begin
        logic redir;
        if (ready_rand) out_ready <= ($urandom % 4) != 0;
        if (rand_mode) begin
            redir = ($urandom % 16) == 0;
            redirect_valid <= redir;
            redirect_pc    <= `FE_RESET_PC + 4 * ($urandom % 64);
            update_valid   <= redir && ($urandom % 2) == 0; // Training rides on a redirect
            update_pc      <= `FE_RESET_PC + 4 * ($urandom % 64);
            update_target  <= `FE_RESET_PC + 4 * ($urandom % 64);
            update_taken   <= ($urandom % 3) != 0;
        end
    end

    task automatic stop_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic wait_items(input int n, input int limit);
        int start;
        int cycles;
        start  = delivered;
        cycles = 0;
        while (delivered - start < n) begin
            @(posedge clk);
            if (++cycles > limit) stop_on_timeout("delivered instructions");
        end
    endtask

    task automatic redirect_to(input addr_t pc, input logic upd, input addr_t upc,
                               input addr_t utgt, input logic utaken);
        @(posedge clk);
        redirect_valid <= 1'b1;
        redirect_pc    <= pc;
        update_valid   <= upd & 1'b1;
        update_pc      <= upc;
        update_target  <= utgt;
        update_taken   <= utaken;
        @(posedge clk);
        redirect_valid <= 1'b0;
        update_valid   <= 1'b0;
    endtask

    task automatic fetch_at(input addr_t pc, input logic exp_taken, input addr_t exp_tgt);
        redirect_to(pc, 1'b0, '0, '0, 1'b0);
        wait_items(1, 200);
        check_pc(last_pc, pc);
        check_pred(last_taken, last_target, exp_taken, exp_tgt);
    endtask

    task automatic report(input string name, input int err_before);
        tests_run++;
        if (errors + imem0.violations == err_before) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: failed", name);
            tests_failed++;
        end
    endtask

    initial begin
        int base;
        int cycles;
        int acks;
        void'($urandom(32'ha70b));
        arst_n         = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        update_valid   = 1'b0;
        update_pc      = '0;
        update_target  = '0;
        update_taken   = 1'b0;
        out_ready      = 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);

        // ============================================================
        // Sequential fetch, then random redirects and updates
        // ============================================================
        base = errors + imem0.violations;
        ready_rand = 1'b1;
        wait_items(24, 1000);
        report("sequential fetch", base);

        base = errors + imem0.violations;
        @(negedge clk);
        rand_mode = 1'b1;
        wait_items(200, 8000);
        @(negedge clk);
        rand_mode = 1'b0;
        @(posedge clk);
        redirect_valid <= 1'b0;
        update_valid   <= 1'b0;
        report("random stream and bus protocol", base);

        // ============================================================
        // Back-pressure
        // ============================================================
        base = errors + imem0.violations;
        @(negedge clk);
        ready_rand = 1'b0;
        @(posedge clk);
        out_ready <= 1'b0;
        redirect_to(`FE_RESET_PC, 1'b0, '0, '0, 1'b0);
        cycles = 0;
        do begin
            @(negedge clk);
            if (++cycles > 50) stop_on_timeout("the bus to go idle");
        end while (wb_cyc);
        acks = 0;
        while (!buffer_full) begin
            @(negedge clk);
            if (wb_ack) acks++;
            if (++cycles > 200) stop_on_timeout("buffer_full");
        end
        if (acks != `FE_BUF_DEPTH) begin
            $display("Buffer filled after %0d fetches instead of %0d", acks, `FE_BUF_DEPTH);
            errors++;
        end
        repeat (16) begin
            @(negedge clk);
            if (wb_cyc) begin
                $display("Bus cycle active while the buffer was full at %0t", $time);
                errors++;
            end
        end
        @(posedge clk);
        out_ready <= 1'b1;
        wait_items(`FE_BUF_DEPTH, 200);
        report("back-pressure", base);

        // ============================================================
        // Prediction and redirects
        // ============================================================
        base = errors + imem0.violations;
        redirect_to(32'h2000, 1'b1, 32'h2010, 32'h2400, 1'b1);
        redirect_to(32'h2000, 1'b1, 32'h2010, 32'h2400, 1'b1);
        cycles = 0;
        while (last_pc != 32'h2010) begin
            wait_items(1, 200);
            if (++cycles > 16) stop_on_timeout("the trained pc");
        end
        check_pred(last_taken, last_target, 1'b1, 32'h2400);
        wait_items(1, 200);
        check_pc(last_pc, 32'h2400);
        report("prediction", base);

        base = errors + imem0.violations;
        cycles = 0;
        do begin
            @(negedge clk);
            if (++cycles > 100) stop_on_timeout("a bus cycle");
        end while (!(wb_cyc && !wb_ack));
        redirect_to(32'h5000, 1'b0, '0, '0, 1'b0);
        wait_items(1, 200);
        check_pc(last_pc, 32'h5000);
        report("redirect during bus cycle", base);

        base = errors + imem0.violations;
        repeat (3) redirect_to(32'h7000, 1'b1, 32'h6000, 32'h6800, 1'b1);
        redirect_to(32'h7000, 1'b1, 32'h6000, 32'h6800, 1'b0);
        fetch_at(32'h6000, 1'b1, 32'h6800); // Counter back at 2, still taken
        redirect_to(32'h7000, 1'b1, 32'h6000, 32'h6800, 1'b0);
        fetch_at(32'h6000, 1'b0, 32'h6004);
        repeat (2) redirect_to(32'h7000, 1'b1, 32'h6000, 32'h6800, 1'b1);
        fetch_at(32'h6400, 1'b0, 32'h6404); // Same index, other tag
        report("counter and tag rules", base);

        $display("Summary: %0d tests, %0d failed, %0d errors, %0d protocol violations",
                 tests_run, tests_failed, errors, imem0.violations);
        if (tests_failed == 0 && errors == 0 && imem0.violations == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/imem_wb_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module imem_wb_slave
    import fetch_types_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  wb_cyc,
    input  logic  wb_stb,
    input  addr_t wb_adr,
    output inst_t wb_dat,
    output logic  wb_ack
);

    int unsigned wait_left;
    logic        busy;
    addr_t       adr_q;
    int          violations = 0;

    // Memory contents are a pattern over every address bit, salted with the seed
    function automatic inst_t mem_word(input addr_t adr);
        return {adr[15:0] ^ 16'ha70b, ~adr[31:16]};
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack    <= 1'b0;
            wb_dat    <= '0;
            busy      <= 1'b0;
            adr_q     <= '0;
            wait_left <= 0;
        end else begin
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !wb_ack) begin
                if (!busy) begin
                    busy      <= 1'b1;
                    adr_q     <= wb_adr;
                    wait_left <= $urandom % 4; // 0 to 3 wait states
                end else if (wait_left == 0) begin
                    wb_ack <= 1'b1;
                    wb_dat <= mem_word(adr_q);
                    busy   <= 1'b0;
                end else begin
                    wait_left <= wait_left - 1;
                end
            end
        end
    end

    // ============================================================
    // Protocol monitor
    // ============================================================

    always @(posedge clk) begin
        if (arst_n) begin
            if (wb_stb && !wb_cyc) begin
                $display("Bus protocol violation at %0t: strobe high without cycle", $time);
                violations++;
            end
            if (busy && wb_cyc && wb_adr != adr_q) begin
                $display("Bus protocol violation at %0t: address changed during a cycle",
                         $time);
                violations++;
            end
            if (busy && !wb_cyc) begin
                $display("Bus protocol violation at %0t: cycle ended before ack", $time);
                violations++;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/frontend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_top
    import fetch_types_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,

    // Wishbone classic read master
    output logic  wb_cyc,
    output logic  wb_stb,
    output addr_t wb_adr,
    input  inst_t wb_dat_i,
    input  logic  wb_ack,

    input  logic  redirect_valid,
    input  addr_t redirect_pc,

    input  logic  update_valid,
    input  addr_t update_pc,
    input  addr_t update_target,
    input  logic  update_taken,

    output logic  out_valid,
    input  logic  out_ready,
    output addr_t out_pc,
    output inst_t out_inst,
    output logic  out_pred_taken,
    output addr_t out_pred_target,

    output logic  buffer_full
);

    addr_t pc;
    logic  pred_taken;
    addr_t pred_target;
    logic  fetch_done;

    pc_reg u_pc_reg (
        .clk, .arst_n,
        .redirect_valid, .redirect_pc,
        .fetch_done, .pred_taken, .pred_target,
        .pc
    );

    bpu u_bpu (
        .clk, .arst_n,
        .pc,
        .update_valid, .update_taken, .update_pc, .update_target,
        .pred_taken, .pred_target
    );

    fetch_fsm u_fetch_fsm (
        .clk, .arst_n,
        .pc, .full(buffer_full), .redirect_valid,
        .wb_cyc, .wb_stb, .wb_adr, .wb_ack,
        .fetch_done
    );

    // The pc holds still during BUS, so the prediction matches the word on the bus
    inst_buffer u_inst_buffer (
        .clk, .arst_n,
        .flush(redirect_valid),
        .wr_en(fetch_done), .wr_pc(wb_adr), .wr_inst(wb_dat_i),
        .wr_pred_taken(pred_taken), .wr_pred_target(pred_target),
        .out_valid, .out_ready, .out_pc, .out_inst,
        .out_pred_taken, .out_pred_target,
        .full(buffer_full)
    );

endmodule

`default_nettype wire

/* rtl/inst_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "frontend_cfg.svh"

module inst_buffer
    import fetch_types_pkg::*;
#(
    parameter int DEPTH = `FE_BUF_DEPTH
)(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  flush,

    input  logic  wr_en,
    input  addr_t wr_pc,
    input  inst_t wr_inst,
    input  logic  wr_pred_taken,
    input  addr_t wr_pred_target,

    output logic  out_valid,
    input  logic  out_ready,
    output addr_t out_pc,
    output inst_t out_inst,
    output logic  out_pred_taken,
    output addr_t out_pred_target,

    output logic  full
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    addr_t pc_mem     [DEPTH];
    inst_t inst_mem   [DEPTH];
    logic  taken_mem  [DEPTH];
    addr_t target_mem [DEPTH];

    logic [PTR_BITS-1:0] wr_ptr, rd_ptr;
    buf_count_t          count;
    logic                do_wr, do_rd;

    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
        return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full      = (count == buf_count_t'(DEPTH));
    assign out_valid = (count != '0);
    assign do_wr     = wr_en && !full;
    assign do_rd     = out_valid && out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
            if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Push and pop cancel out
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            pc_mem[wr_ptr]     <= wr_pc;
            inst_mem[wr_ptr]   <= wr_inst;
            taken_mem[wr_ptr]  <= wr_pred_taken;
            target_mem[wr_ptr] <= wr_pred_target;
        end
    end

    // Head of the queue is presented directly
    assign out_pc          = pc_mem[rd_ptr];
    assign out_inst        = inst_mem[rd_ptr];
    assign out_pred_taken  = taken_mem[rd_ptr];
    assign out_pred_target = target_mem[rd_ptr];

    a_no_write_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        wr_en |-> !full
    ) else $error("inst_buffer: write attempted while full");

endmodule

`default_nettype wire

/* rtl/fetch_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_fsm
    import fetch_types_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,

    input  addr_t pc,
    input  logic  full,
    input  logic  redirect_valid,

    output logic  wb_cyc,
    output logic  wb_stb,
    output addr_t wb_adr,
    input  logic  wb_ack,

    output logic  fetch_done
);

    fetch_state_e state, state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (!full && !redirect_valid) state_nxt = BUS;
            BUS: begin
                if (wb_ack) state_nxt = IDLE;
                else if (redirect_valid) state_nxt = DISCARD; // Word is stale once it lands
            end
            DISCARD: if (wb_ack) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= IDLE;
            wb_adr <= '0;
        end else begin
            state <= state_nxt;
            if (state == IDLE && state_nxt == BUS) wb_adr <= pc; // Held for the whole cycle
        end
    end

    // Both strobes follow the state, so they drop together the cycle after ack
    assign wb_cyc = (state != IDLE);
    assign wb_stb = (state != IDLE);

    // An ack that coincides with a redirect carries a word nobody wants
    assign fetch_done = (state == BUS) && wb_ack && !redirect_valid;

    // ============================================================
    // Checks
    // ============================================================

    a_wb_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        (wb_stb && !wb_ack) |=> (wb_stb && wb_cyc && $stable(wb_adr))
    ) else $error("fetch_fsm: request dropped or address moved before ack");

    a_done_not_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        fetch_done |-> !full
    ) else $error("fetch_fsm: fetch completed into a full buffer");

endmodule

`default_nettype wire

/* rtl/bpu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "frontend_cfg.svh"

module bpu
    import fetch_types_pkg::*, branch_types_pkg::*;
#(
    parameter int INDEX_BITS = `FE_BTB_INDEX_BITS
)(
    input  logic  clk,
    input  logic  arst_n,

    input  addr_t pc,

    input  logic  update_valid,
    input  logic  update_taken,
    input  addr_t update_pc,
    input  addr_t update_target,

    output logic  pred_taken,
    output addr_t pred_target
);

    localparam int ENTRIES = 2 ** INDEX_BITS;

    logic [ENTRIES-1:0] valid_q;
    btb_tag_t           tag_mem    [ENTRIES];
    addr_t              target_mem [ENTRIES];
    sat_cnt_t           cnt_mem    [ENTRIES];

    btb_index_t rd_idx;
    btb_tag_t   rd_tag;
    logic       rd_hit;
    btb_index_t wr_idx;
    btb_tag_t   wr_tag;
    logic       wr_hit;

    // ============================================================
    // Lookup
    // ============================================================

    assign rd_idx = pc[INDEX_BITS+1:2];
    assign rd_tag = pc[31:INDEX_BITS+2];
    assign rd_hit = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);

    assign pred_taken  = rd_hit && cnt_mem[rd_idx][1]; // Upper counter bit set means 2 or 3
    // Not taken predicts the fall-through word
    assign pred_target = pred_taken ? target_mem[rd_idx] : pc + 32'd4;

    // ============================================================
    // Training
    // ============================================================

    assign wr_idx = update_pc[INDEX_BITS+1:2];
    assign wr_tag = update_pc[31:INDEX_BITS+2];
    assign wr_hit = valid_q[wr_idx] && (tag_mem[wr_idx] == wr_tag);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (update_valid && update_taken && !wr_hit) begin
            valid_q[wr_idx] <= 1'b1; // Allocate on a taken miss
        end
    end

    always_ff @(posedge clk) begin
        if (update_valid) begin
            if (update_taken) begin
                target_mem[wr_idx] <= update_target;
                if (!wr_hit) begin
                    tag_mem[wr_idx] <= wr_tag;
                    cnt_mem[wr_idx] <= 2'd2; // New entries start weakly taken
                end else if (cnt_mem[wr_idx] != 2'd3) begin
                    cnt_mem[wr_idx] <= cnt_mem[wr_idx] + 2'd1;
                end
            end else if (wr_hit && cnt_mem[wr_idx] != 2'd0) begin
                cnt_mem[wr_idx] <= cnt_mem[wr_idx] - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/pc_reg.sv */
`timescale 1ns/1ps
`default_nettype none

`include "frontend_cfg.svh"

module pc_reg
    import fetch_types_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,

    input  logic  redirect_valid,
    input  addr_t redirect_pc,

    input  logic  fetch_done,
    input  logic  pred_taken,
    input  addr_t pred_target,

    output addr_t pc
);

    addr_t seq_pc;

    assign seq_pc = pc + 32'd4;

    // Redirect from the back end wins over the local advance
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `FE_RESET_PC;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
        end else if (fetch_done) begin
            pc <= pred_taken ? pred_target : seq_pc; // Follow the BTB when it says taken
        end
    end

    // ============================================================
    // Checks
    // ============================================================

    // Redirect and BTB targets must both keep word alignment
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!arst_n)
        pc[1:0] == 2'b00
    ) else $error("pc_reg: fetch pc %h is not word aligned", pc);

endmodule

`default_nettype wire

/* rtl/branch_types_pkg.sv */
`default_nettype none

`include "frontend_cfg.svh"

package branch_types_pkg;

    // Index takes pc bits above the word offset, the tag takes the rest
    typedef logic [`FE_BTB_INDEX_BITS-1:0]      btb_index_t;
    typedef logic [31-`FE_BTB_INDEX_BITS-2:0]   btb_tag_t;

    typedef logic [1:0] sat_cnt_t; // 2 and 3 predict taken

endpackage

`default_nettype wire

/* rtl/fetch_types_pkg.sv */
`default_nettype none

`include "frontend_cfg.svh"

package fetch_types_pkg;

    typedef logic [31:0] addr_t; // Byte address, bits 1:0 stay zero
    typedef logic [31:0] inst_t; // Opaque to the front end

    // Occupancy has to reach the full depth, not just depth - 1
    typedef logic [$clog2(`FE_BUF_DEPTH + 1)-1:0] buf_count_t;

    typedef enum logic [1:0] {
        IDLE,
        BUS,     // Read cycle outstanding, word is wanted
        DISCARD  // Read cycle outstanding, word is dropped
    } fetch_state_e;

endpackage

`default_nettype wire

/* include/frontend_cfg.svh */
`ifndef FRONTEND_CFG_SVH
`define FRONTEND_CFG_SVH

// ============================================================
// Front end configuration
// ============================================================

// First fetch address after reset
`define FE_RESET_PC 32'h0000_1000

`define FE_BUF_DEPTH 4 // Instruction buffer entries

// Index bits of the branch target buffer, 16 entries
`define FE_BTB_INDEX_BITS 4

`endif
